//--- branch_group_decoder.sv
`timescale 1ns/10ps

module branch_group_decoder
    import decode_pkg::*;
(
    input  fetch_t fetch_i,
    output logic   hit_o,
    output dec_t   dec_o
);

    logic [6:0] op7;
    logic [5:0] op6;
    alu_op_e    aluop;

    assign op7   = fetch_i.inst[31:25];
    assign op6   = fetch_i.inst[31:26];
    assign hit_o = aluop != alu_nop;

    always_comb begin
        aluop = alu_nop;
        if (op7 == op7_lu12iw) begin
            aluop = alu_lu12i;
        end else if (op7 == op7_pcaddu12i) begin
            aluop = alu_pcaddu12i;
        end else begin
            case (op6)
                op6_beq:  aluop = alu_beq;
                op6_bne:  aluop = alu_bne;
                op6_blt:  aluop = alu_blt;
                op6_bge:  aluop = alu_bge;
                op6_bltu: aluop = alu_bltu;
                op6_bgeu: aluop = alu_bgeu;
                op6_b:    aluop = alu_b;
                op6_bl:   aluop = alu_bl;
                op6_jirl: aluop = alu_jirl;
                default:  aluop = alu_nop;
            endcase
        end
    end

    always_comb begin
        dec_o = dec_idle(fetch_i);
        if (hit_o) begin
            dec_o.aluop      = aluop;
            dec_o.alusel     = sel_jump_branch;
            dec_o.inst_valid = 1'b1;
            case (aluop)
                alu_lu12i: begin
                    dec_o.alusel    = sel_logic;
                    dec_o.rd_en_a   = 1'b1;
                    dec_o.rd_addr_a = '0; // r0 | imm
                    dec_o.wr_en     = 1'b1;
                    dec_o.wr_addr   = rd_of(fetch_i.inst);
                    dec_o.imm       = si20_hi(fetch_i.inst);
                end
                alu_pcaddu12i: begin
                    dec_o.alusel  = sel_arith;
                    dec_o.rd_en_a = 1'b1;
                    dec_o.wr_en   = 1'b1;
                    dec_o.wr_addr = rd_of(fetch_i.inst);
                    dec_o.imm     = si20_hi(fetch_i.inst);
                end
                alu_b: begin
                end
                alu_bl: begin
                    dec_o.wr_en   = 1'b1;
                    dec_o.wr_addr = link_reg;
                end
                alu_jirl: begin
                    dec_o.rd_en_a = 1'b1;
                    dec_o.wr_en   = 1'b1;
                    dec_o.wr_addr = rd_of(fetch_i.inst);
                end
                default: begin
                    dec_o.rd_en_a   = 1'b1; // compare rj with rd
                    dec_o.rd_en_b   = 1'b1;
                    dec_o.rd_addr_b = rd_of(fetch_i.inst);
                end
            endcase
        end
    end

endmodule

//--- decode_pkg.sv
package decode_pkg;

    // ==============================
    // widths and fixed registers
    // ==============================
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd1; // bl return address

    // 12-bit-immediate group, inst[31:22]
    localparam logic [9:0] op10_slti  = 10'b0000001000;
    localparam logic [9:0] op10_sltui = 10'b0000001001;
    localparam logic [9:0] op10_addiw = 10'b0000001010;
    localparam logic [9:0] op10_andi  = 10'b0000001101;
    localparam logic [9:0] op10_ori   = 10'b0000001110;
    localparam logic [9:0] op10_xori  = 10'b0000001111;
    localparam logic [9:0] op10_ldb   = 10'b0010100000;
    localparam logic [9:0] op10_ldh   = 10'b0010100001;
    localparam logic [9:0] op10_ldw   = 10'b0010100010;
    localparam logic [9:0] op10_stb   = 10'b0010100100;
    localparam logic [9:0] op10_sth   = 10'b0010100101;
    localparam logic [9:0] op10_stw   = 10'b0010100110;
    localparam logic [9:0] op10_ldbu  = 10'b0010101000;
    localparam logic [9:0] op10_ldhu  = 10'b0010101001;

    // register group, inst[31:15]
    localparam logic [16:0] op17_addw    = 17'h00020;
    localparam logic [16:0] op17_subw    = 17'h00022;
    localparam logic [16:0] op17_slt     = 17'h00024;
    localparam logic [16:0] op17_sltu    = 17'h00025;
    localparam logic [16:0] op17_nor     = 17'h00028;
    localparam logic [16:0] op17_and     = 17'h00029;
    localparam logic [16:0] op17_or      = 17'h0002a;
    localparam logic [16:0] op17_xor     = 17'h0002b;
    localparam logic [16:0] op17_sllw    = 17'h0002e;
    localparam logic [16:0] op17_srlw    = 17'h0002f;
    localparam logic [16:0] op17_sraw    = 17'h00030;
    localparam logic [16:0] op17_mulw    = 17'h00038;
    localparam logic [16:0] op17_mulhw   = 17'h00039;
    localparam logic [16:0] op17_mulhwu  = 17'h0003a;
    localparam logic [16:0] op17_divw    = 17'h00040;
    localparam logic [16:0] op17_modw    = 17'h00041;
    localparam logic [16:0] op17_divwu   = 17'h00042;
    localparam logic [16:0] op17_modwu   = 17'h00043;
    localparam logic [16:0] op17_break   = 17'h00054;
    localparam logic [16:0] op17_syscall = 17'h00056;
    localparam logic [16:0] op17_slliw   = 17'h00081;
    localparam logic [16:0] op17_srliw   = 17'h00089;
    localparam logic [16:0] op17_sraiw   = 17'h00091;

    localparam logic [6:0] op7_lu12iw    = 7'b0001010; // inst[31:25]
    localparam logic [6:0] op7_pcaddu12i = 7'b0001110;

    // branches and jumps, inst[31:26]
    localparam logic [5:0] op6_jirl = 6'b010011;
    localparam logic [5:0] op6_b    = 6'b010100;
    localparam logic [5:0] op6_bl   = 6'b010101;
    localparam logic [5:0] op6_beq  = 6'b010110;
    localparam logic [5:0] op6_bne  = 6'b010111;
    localparam logic [5:0] op6_blt  = 6'b011000;
    localparam logic [5:0] op6_bge  = 6'b011001;
    localparam logic [5:0] op6_bltu = 6'b011010;
    localparam logic [5:0] op6_bgeu = 6'b011011;

    // ==============================
    // enums and bundles
    // ==============================
    typedef enum logic [7:0] {
        alu_nop, alu_slti, alu_sltui, alu_addiw, alu_andi, alu_ori, alu_xori,
        alu_ldb, alu_ldh, alu_ldw, alu_ldbu, alu_ldhu, alu_stb, alu_sth, alu_stw,
        alu_addw, alu_subw, alu_slt, alu_sltu, alu_nor, alu_and, alu_or, alu_xor,
        alu_sllw, alu_srlw, alu_sraw, alu_mulw, alu_mulhw, alu_mulhwu,
        alu_divw, alu_modw, alu_divwu, alu_modwu, alu_slliw, alu_srliw, alu_sraiw,
        alu_break, alu_syscall, alu_lu12i, alu_pcaddu12i,
        alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu, alu_b, alu_bl, alu_jirl
    } alu_op_e;

    typedef enum logic [2:0] {
        sel_nop, sel_logic, sel_shift, sel_arith, sel_load_store, sel_jump_branch
    } alu_sel_e;

    typedef enum logic [5:0] {
        exc_none = 6'h00,
        exc_pif  = 6'h03, // fetch page invalid
        exc_adef = 6'h08, // fetch address error
        exc_sys  = 6'h0b,
        exc_brk  = 6'h0c,
        exc_ine  = 6'h0d
    } exc_cause_e;

    typedef struct packed {
        logic [word_w-1:0] pc;
        logic [word_w-1:0] inst;
        logic              fetch_exc;
        exc_cause_e        fetch_cause;
    } fetch_t;

    typedef struct packed {
        logic [word_w-1:0]     pc;
        alu_op_e               aluop;
        alu_sel_e              alusel;
        logic                  rd_en_a;
        logic [reg_addr_w-1:0] rd_addr_a;
        logic                  rd_en_b;
        logic [reg_addr_w-1:0] rd_addr_b;
        logic                  wr_en;
        logic [reg_addr_w-1:0] wr_addr;
        logic [word_w-1:0]     imm;
        logic                  inst_valid;
        logic                  exc;
        exc_cause_e            exc_cause;
    } dec_t;

    // ==============================
    // field helpers
    // ==============================
    function automatic logic [reg_addr_w-1:0] rj_of(input logic [word_w-1:0] inst);
        return inst[9:5];
    endfunction

    function automatic logic [reg_addr_w-1:0] rk_of(input logic [word_w-1:0] inst);
        return inst[14:10];
    endfunction

    function automatic logic [reg_addr_w-1:0] rd_of(input logic [word_w-1:0] inst);
        return inst[4:0];
    endfunction

    function automatic logic [word_w-1:0] si12_sext(input logic [word_w-1:0] inst);
        return {{20{inst[21]}}, inst[21:10]};
    endfunction

    function automatic logic [word_w-1:0] ui12_zext(input logic [word_w-1:0] inst);
        return {20'b0, inst[21:10]};
    endfunction

    function automatic logic [word_w-1:0] si20_hi(input logic [word_w-1:0] inst);
        return {inst[24:5], 12'b0};
    endfunction

    function automatic logic [word_w-1:0] ui5_zext(input logic [word_w-1:0] inst);
        return {27'b0, inst[14:10]};
    endfunction

    // bundle for a word that no group claims
    function automatic dec_t dec_idle(input fetch_t f);
        dec_t d;
        d.pc         = f.pc;
        d.aluop      = alu_nop;
        d.alusel     = sel_nop;
        d.rd_en_a    = 1'b0;
        d.rd_addr_a  = rj_of(f.inst);
        d.rd_en_b    = 1'b0;
        d.rd_addr_b  = rk_of(f.inst);
        d.wr_en      = 1'b0;
        d.wr_addr    = '0;
        d.imm        = '0;
        d.inst_valid = 1'b0;
        d.exc        = 1'b0;
        d.exc_cause  = exc_none;
        return d;
    endfunction

endpackage

//--- id_stage.sv
`timescale 1ns/10ps

module id_stage
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  logic   in_valid_i,
    input  fetch_t in_data_i,
    output logic   in_ready_o,
    output logic   out_valid_o,
    output dec_t   out_data_o,
    input  logic   out_ready_i
);

    fetch_t fetch_q;
    logic   fetch_valid;
    logic   dec_ready;
    logic   imm_hit;
    logic   reg_hit;
    logic   br_hit;
    logic   any_hit;
    dec_t   imm_dec;
    dec_t   reg_dec;
    dec_t   br_dec;
    dec_t   merged;

    stage_reg #(
        .payload_t(fetch_t)
    ) u_fetch_reg (
        .clk    (clk),
        .reset_i(reset_i),
        .valid_i(in_valid_i),
        .data_i (in_data_i),
        .ready_o(in_ready_o),
        .valid_o(fetch_valid),
        .data_o (fetch_q),
        .ready_i(dec_ready)
    );

    imm_group_decoder u_imm_dec (
        .fetch_i(fetch_q),
        .hit_o  (imm_hit),
        .dec_o  (imm_dec)
    );

    reg_group_decoder u_reg_dec (
        .fetch_i(fetch_q),
        .hit_o  (reg_hit),
        .dec_o  (reg_dec)
    );

    branch_group_decoder u_br_dec (
        .fetch_i(fetch_q),
        .hit_o  (br_hit),
        .dec_o  (br_dec)
    );

    // ==============================
    // merge and exception priority
    // ==============================
    assign any_hit = imm_hit || reg_hit || br_hit;

    always_comb begin
        if (imm_hit) begin
            merged = imm_dec;
        end else if (reg_hit) begin
            merged = reg_dec;
        end else if (br_hit) begin
            merged = br_dec;
        end else begin
            merged = dec_idle(fetch_q);
        end

        if (fetch_q.fetch_exc) begin
            merged.exc       = 1'b1; // fetch fault wins
            merged.exc_cause = fetch_q.fetch_cause;
        end else if (!merged.exc && !any_hit && fetch_q.inst != '0) begin
            merged.exc       = 1'b1;
            merged.exc_cause = exc_ine;
        end
    end

    stage_reg #(
        .payload_t(dec_t)
    ) u_dec_reg (
        .clk    (clk),
        .reset_i(reset_i),
        .valid_i(fetch_valid),
        .data_i (merged),
        .ready_o(dec_ready),
        .valid_o(out_valid_o),
        .data_o (out_data_o),
        .ready_i(out_ready_i)
    );

    // opcode spaces of the three groups are disjoint
    a_one_hit: assert property (
        @(posedge clk) disable iff (reset_i)
        fetch_valid |-> $onehot0({imm_hit, reg_hit, br_hit})
    );

endmodule

//--- imm_group_decoder.sv
`timescale 1ns/10ps

module imm_group_decoder
    import decode_pkg::*;
(
    input  fetch_t fetch_i,
    output logic   hit_o,
    output dec_t   dec_o
);

    logic [9:0] op10;
    alu_op_e    aluop;
    logic       is_store;

    assign op10  = fetch_i.inst[31:22];
    assign hit_o = aluop != alu_nop;

    always_comb begin
        aluop = alu_nop;
        case (op10)
            op10_slti:  aluop = alu_slti;
            op10_sltui: aluop = alu_sltui;
            op10_addiw: aluop = alu_addiw;
            op10_andi:  aluop = alu_andi;
            op10_ori:   aluop = alu_ori;
            op10_xori:  aluop = alu_xori;
            op10_ldb:   aluop = alu_ldb;
            op10_ldh:   aluop = alu_ldh;
            op10_ldw:   aluop = alu_ldw;
            op10_ldbu:  aluop = alu_ldbu;
            op10_ldhu:  aluop = alu_ldhu;
            op10_stb:   aluop = alu_stb;
            op10_sth:   aluop = alu_sth;
            op10_stw:   aluop = alu_stw;
            default:    aluop = alu_nop;
        endcase
    end

    assign is_store = aluop inside {alu_stb, alu_sth, alu_stw};

    always_comb begin
        dec_o = dec_idle(fetch_i);
        if (hit_o) begin
            dec_o.aluop      = aluop;
            dec_o.rd_en_a    = 1'b1; // base or source in rj
            dec_o.inst_valid = 1'b1;
            dec_o.imm        = si12_sext(fetch_i.inst);
            case (aluop)
                alu_slti, alu_sltui: begin
                    dec_o.alusel = sel_shift; // compare lives beside the shifter
                end
                alu_addiw: begin
                    dec_o.alusel = sel_arith;
                end
                alu_andi, alu_ori, alu_xori: begin
                    dec_o.alusel = sel_logic;
                    dec_o.imm    = ui12_zext(fetch_i.inst);
                end
                default: begin
                    dec_o.alusel = sel_load_store;
                end
            endcase
            if (is_store) begin
                dec_o.rd_en_b   = 1'b1;
                dec_o.rd_addr_b = rd_of(fetch_i.inst); // store data
            end else begin
                dec_o.wr_en   = 1'b1;
                dec_o.wr_addr = rd_of(fetch_i.inst);
            end
        end
    end

endmodule

//--- reg_group_decoder.sv
`timescale 1ns/10ps

module reg_group_decoder
    import decode_pkg::*;
(
    input  fetch_t fetch_i,
    output logic   hit_o,
    output dec_t   dec_o
);

    logic [16:0] op17;
    alu_op_e     aluop;

    assign op17  = fetch_i.inst[31:15];
    assign hit_o = aluop != alu_nop;

    always_comb begin
        aluop = alu_nop;
        case (op17)
            op17_addw:    aluop = alu_addw;
            op17_subw:    aluop = alu_subw;
            op17_slt:     aluop = alu_slt;
            op17_sltu:    aluop = alu_sltu;
            op17_nor:     aluop = alu_nor;
            op17_and:     aluop = alu_and;
            op17_or:      aluop = alu_or;
            op17_xor:     aluop = alu_xor;
            op17_sllw:    aluop = alu_sllw;
            op17_srlw:    aluop = alu_srlw;
            op17_sraw:    aluop = alu_sraw;
            op17_mulw:    aluop = alu_mulw;
            op17_mulhw:   aluop = alu_mulhw;
            op17_mulhwu:  aluop = alu_mulhwu;
            op17_divw:    aluop = alu_divw;
            op17_modw:    aluop = alu_modw;
            op17_divwu:   aluop = alu_divwu;
            op17_modwu:   aluop = alu_modwu;
            op17_slliw:   aluop = alu_slliw;
            op17_srliw:   aluop = alu_srliw;
            op17_sraiw:   aluop = alu_sraiw;
            op17_break:   aluop = alu_break;
            op17_syscall: aluop = alu_syscall;
            default:      aluop = alu_nop;
        endcase
    end

    always_comb begin
        dec_o = dec_idle(fetch_i);
        if (hit_o) begin
            dec_o.aluop      = aluop;
            dec_o.inst_valid = 1'b1;
            case (aluop)
                alu_break, alu_syscall: begin
                    dec_o.exc       = 1'b1; // trap, no register traffic
                    dec_o.exc_cause = (aluop == alu_break) ? exc_brk : exc_sys;
                end
                alu_slliw, alu_srliw, alu_sraiw: begin
                    dec_o.alusel  = sel_shift;
                    dec_o.rd_en_a = 1'b1;
                    dec_o.wr_en   = 1'b1;
                    dec_o.wr_addr = rd_of(fetch_i.inst);
                    dec_o.imm     = ui5_zext(fetch_i.inst); // shift amount
                end
                default: begin
                    // rd = rj op rk
                    if (aluop inside {alu_nor, alu_and, alu_or, alu_xor}) begin
                        dec_o.alusel = sel_logic;
                    end else if (aluop inside {alu_sllw, alu_srlw, alu_sraw}) begin
                        dec_o.alusel = sel_shift;
                    end else begin
                        dec_o.alusel = sel_arith;
                    end
                    dec_o.rd_en_a = 1'b1;
                    dec_o.rd_en_b = 1'b1;
                    dec_o.wr_en   = 1'b1;
                    dec_o.wr_addr = rd_of(fetch_i.inst);
                end
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tb_id_stage -f vlog.f -o sim_id_stage \
    && ./obj_dir/sim_id_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the entry leaves this cycle
    assign ready_o = !valid_q || ready_i;
    assign valid_o = valid_q;
    assign data_o  = data_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    // ==============================
    // checks
    // ==============================
    a_hold_stalled: assert property (
        @(posedge clk) disable iff (reset_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o))
    );

    a_empty_after_reset: assert property (
        @(posedge clk) reset_i |=> !valid_o
    );

endmodule

//--- tb_id_ref.svh
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

// ==============================
// opcode table
// ==============================
logic [31:0] op_match [64];
int          op_bits  [64];
alu_op_e     op_alu   [64];
int          op_n = 0;

function automatic void add_op(input logic [31:0] m, input int bits, input alu_op_e a);
    op_match[op_n] = m;
    op_bits[op_n]  = bits;
    op_alu[op_n]   = a;
    op_n++;
endfunction

task automatic load_op_table();
    add_op({op10_slti, 22'b0}, 10, alu_slti);
    add_op({op10_sltui, 22'b0}, 10, alu_sltui);
    add_op({op10_addiw, 22'b0}, 10, alu_addiw);
    add_op({op10_andi, 22'b0}, 10, alu_andi);
    add_op({op10_ori, 22'b0}, 10, alu_ori);
    add_op({op10_xori, 22'b0}, 10, alu_xori);
    add_op({op10_ldb, 22'b0}, 10, alu_ldb);
    add_op({op10_ldh, 22'b0}, 10, alu_ldh);
    add_op({op10_ldw, 22'b0}, 10, alu_ldw);
    add_op({op10_ldbu, 22'b0}, 10, alu_ldbu);
    add_op({op10_ldhu, 22'b0}, 10, alu_ldhu);
    add_op({op10_stb, 22'b0}, 10, alu_stb);
    add_op({op10_sth, 22'b0}, 10, alu_sth);
    add_op({op10_stw, 22'b0}, 10, alu_stw);
    add_op({op17_addw, 15'b0}, 17, alu_addw);
    add_op({op17_subw, 15'b0}, 17, alu_subw);
    add_op({op17_slt, 15'b0}, 17, alu_slt);
    add_op({op17_sltu, 15'b0}, 17, alu_sltu);
    add_op({op17_nor, 15'b0}, 17, alu_nor);
    add_op({op17_and, 15'b0}, 17, alu_and);
    add_op({op17_or, 15'b0}, 17, alu_or);
    add_op({op17_xor, 15'b0}, 17, alu_xor);
    add_op({op17_sllw, 15'b0}, 17, alu_sllw);
    add_op({op17_srlw, 15'b0}, 17, alu_srlw);
    add_op({op17_sraw, 15'b0}, 17, alu_sraw);
    add_op({op17_mulw, 15'b0}, 17, alu_mulw);
    add_op({op17_mulhw, 15'b0}, 17, alu_mulhw);
    add_op({op17_mulhwu, 15'b0}, 17, alu_mulhwu);
    add_op({op17_divw, 15'b0}, 17, alu_divw);
    add_op({op17_modw, 15'b0}, 17, alu_modw);
    add_op({op17_divwu, 15'b0}, 17, alu_divwu);
    add_op({op17_modwu, 15'b0}, 17, alu_modwu);
    add_op({op17_slliw, 15'b0}, 17, alu_slliw);
    add_op({op17_srliw, 15'b0}, 17, alu_srliw);
    add_op({op17_sraiw, 15'b0}, 17, alu_sraiw);
    add_op({op17_break, 15'b0}, 17, alu_break);
    add_op({op17_syscall, 15'b0}, 17, alu_syscall);
    add_op({op7_lu12iw, 25'b0}, 7, alu_lu12i);
    add_op({op7_pcaddu12i, 25'b0}, 7, alu_pcaddu12i);
    add_op({op6_beq, 26'b0}, 6, alu_beq);
    add_op({op6_bne, 26'b0}, 6, alu_bne);
    add_op({op6_blt, 26'b0}, 6, alu_blt);
    add_op({op6_bge, 26'b0}, 6, alu_bge);
    add_op({op6_bltu, 26'b0}, 6, alu_bltu);
    add_op({op6_bgeu, 26'b0}, 6, alu_bgeu);
    add_op({op6_b, 26'b0}, 6, alu_b);
    add_op({op6_bl, 26'b0}, 6, alu_bl);
    add_op({op6_jirl, 26'b0}, 6, alu_jirl);
endtask

function automatic logic [31:0] op_mask(input int bits);
    return ~(32'hffff_ffff >> bits);
endfunction

function automatic alu_op_e ref_op(input logic [31:0] w);
    for (int i = 0; i < op_n; i++) begin
        if ((w & op_mask(op_bits[i])) == op_match[i]) begin
            return op_alu[i];
        end
    end
    return alu_nop;
endfunction

// ==============================
// expected bundle
// ==============================
function automatic dec_t ref_decode(input fetch_t f);
    dec_t              e;
    alu_op_e           op;
    logic [word_w-1:0] w;
    w = f.inst;
    op = ref_op(w);
    e = '0;
    e.pc         = f.pc;
    e.aluop      = op;
    e.alusel     = sel_nop;
    e.exc_cause  = exc_none;
    e.rd_addr_a  = rj_of(w);
    e.rd_addr_b  = rk_of(w);
    e.inst_valid = op != alu_nop;
    if (op inside {alu_slti, alu_sltui, alu_addiw, alu_andi, alu_ori, alu_xori,
                   alu_ldb, alu_ldh, alu_ldw, alu_ldbu, alu_ldhu,
                   alu_stb, alu_sth, alu_stw}) begin
        e.rd_en_a = 1'b1;
        e.imm     = si12_sext(w);
        if (op inside {alu_andi, alu_ori, alu_xori}) begin
            e.alusel = sel_logic;
            e.imm    = ui12_zext(w);
        end else if (op inside {alu_slti, alu_sltui}) begin
            e.alusel = sel_shift;
        end else if (op == alu_addiw) begin
            e.alusel = sel_arith;
        end else begin
            e.alusel = sel_load_store;
        end
        if (op inside {alu_stb, alu_sth, alu_stw}) begin
            e.rd_en_b   = 1'b1;
            e.rd_addr_b = rd_of(w); // store data
        end else begin
            e.wr_en   = 1'b1;
            e.wr_addr = rd_of(w);
        end
    end else if (op == alu_break || op == alu_syscall) begin
        e.exc       = 1'b1;
        e.exc_cause = (op == alu_break) ? exc_brk : exc_sys;
    end else if (op inside {alu_slliw, alu_srliw, alu_sraiw}) begin
        e.alusel  = sel_shift;
        e.rd_en_a = 1'b1;
        e.wr_en   = 1'b1;
        e.wr_addr = rd_of(w);
        e.imm     = ui5_zext(w);
    end else if (op inside {alu_addw, alu_subw, alu_slt, alu_sltu, alu_mulw, alu_mulhw,
                            alu_mulhwu, alu_divw, alu_modw, alu_divwu, alu_modwu}) begin
        e.alusel  = sel_arith;
        e.rd_en_a = 1'b1;
        e.rd_en_b = 1'b1;
        e.wr_en   = 1'b1;
        e.wr_addr = rd_of(w);
    end else if (op inside {alu_nor, alu_and, alu_or, alu_xor,
                            alu_sllw, alu_srlw, alu_sraw}) begin
        e.alusel  = (op inside {alu_sllw, alu_srlw, alu_sraw}) ? sel_shift : sel_logic;
        e.rd_en_a = 1'b1;
        e.rd_en_b = 1'b1;
        e.wr_en   = 1'b1;
        e.wr_addr = rd_of(w);
    end else if (op == alu_lu12i || op == alu_pcaddu12i) begin
        e.alusel  = (op == alu_lu12i) ? sel_logic : sel_arith;
        e.rd_en_a = 1'b1;
        e.wr_en   = 1'b1;
        e.wr_addr = rd_of(w);
        e.imm     = si20_hi(w);
        if (op == alu_lu12i) begin
            e.rd_addr_a = '0; // r0 base
        end
    end else if (op != alu_nop) begin
        e.alusel = sel_jump_branch;
        if (op == alu_bl) begin
            e.wr_en   = 1'b1;
            e.wr_addr = link_reg;
        end else if (op == alu_jirl) begin
            e.rd_en_a = 1'b1;
            e.wr_en   = 1'b1;
            e.wr_addr = rd_of(w);
        end else if (op != alu_b) begin
            e.rd_en_a   = 1'b1; // conditional branch
            e.rd_en_b   = 1'b1;
            e.rd_addr_b = rd_of(w);
        end
    end
    if (f.fetch_exc) begin
        e.exc       = 1'b1;
        e.exc_cause = f.fetch_cause;
    end else if (op == alu_nop && w != '0) begin
        e.exc       = 1'b1;
        e.exc_cause = exc_ine;
    end
    return e;
endfunction

// ==============================
// compare tasks
// ==============================
task automatic check_dec(input string name, input dec_t got, input dec_t exp);
    if (got !== exp) begin
        $display("Error: %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_exc(input string name, input exc_cause_e got, input exc_cause_e exp);
    if (got !== exp) begin
        $display("Error: %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Error: %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

`endif

//--- tb_id_stage.sv
`timescale 1ns/10ps

module tb_id_stage
    import decode_pkg::*;
();

    logic   clk;
    logic   reset_i;
    logic   in_valid_i;
    fetch_t in_data_i;
    logic   in_ready_o;
    logic   out_valid_o;
    dec_t   out_data_o;
    logic   out_ready_i = 1'b1;

    dec_t   exp_q[$];
    int     acc_q[$];    // accept cycle, -1 when latency is not checked
    int     cyc = 0;
    int     n_in = 0;
    int     n_out = 0;
    int     n_sent = 0;
    bit     lat_check = 0;
    bit     bp_on = 0;

    id_stage i_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .in_valid_i (in_valid_i),
        .in_data_i  (in_data_i),
        .in_ready_o (in_ready_o),
        .out_valid_o(out_valid_o),
        .out_data_o (out_data_o),
        .out_ready_i(out_ready_i)
    );

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "tb_id_ref.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // random back-pressure only in the second phase
    always @(posedge clk) begin
        out_ready_i <= bp_on ? ($urandom_range(0, 99) < 60) : 1'b1;
    end

    // ==============================
    // stimulus helpers
    // ==============================
    function automatic fetch_t make_fetch(input logic [31:0] inst, input logic with_exc);
        fetch_t f;
        f.pc          = $urandom() & 32'hffff_fffc;
        f.inst        = inst;
        f.fetch_exc   = with_exc;
        f.fetch_cause = exc_none;
        if (with_exc) begin
            f.fetch_cause = ($urandom_range(0, 1) == 1) ? exc_adef : exc_pif;
        end
        return f;
    endfunction

    function automatic logic [31:0] kept_word(input int i);
        return op_match[i] | ($urandom() & ~op_mask(op_bits[i]));
    endfunction

    function automatic logic [31:0] illegal_word();
        return {1'b1, 31'($urandom())}; // no kept opcode has bit 31 set
    endfunction

    function automatic fetch_t random_fetch();
        int          pick;
        logic [31:0] w;
        pick = $urandom_range(0, 9);
        if (pick < 7) begin
            w = kept_word($urandom_range(0, op_n - 1));
        end else if (pick < 9) begin
            w = illegal_word();
        end else begin
            w = '0;
        end
        return make_fetch(w, $urandom_range(0, 7) == 0);
    endfunction

    task automatic send_item(input fetch_t f);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        in_valid_i <= 1'b1;
        in_data_i  <= f;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready_o; // stable until the next rising edge
            @(posedge clk);
            if (!taken) begin
                waited++;
                if (waited > 200) begin
                    $display("in_ready_o stayed low for 200 cycles");
                    abort_run();
                end
            end
        end
        n_sent++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        in_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > 500) begin
                $display("outputs stopped with %0d items still pending", exp_q.size());
                abort_run();
            end
            @(posedge clk);
        end
    endtask

    // ==============================
    // scoreboard
    // ==============================
    initial begin
        dec_t exp;
        int   acc;
        forever begin
            @(negedge clk);
            if (!reset_i) begin
                check_bit("in_ready_o", in_ready_o, !(exp_q.size() == 2 && !out_ready_i));
                if (out_valid_o && out_ready_i) begin
                    if (exp_q.size() == 0) begin
                        $display("output transfer seen with no input pending");
                        abort_run();
                    end
                    exp = exp_q.pop_front();
                    acc = acc_q.pop_front();
                    check_exc("out_data_o.exc_cause", out_data_o.exc_cause, exp.exc_cause);
                    check_dec("out_data_o", out_data_o, exp);
                    if (acc >= 0 && cyc - acc != 2) begin
                        $display("output arrived %0d cycles after its input", cyc - acc);
                        abort_run();
                    end
                    n_out++;
                end
                if (in_valid_i && in_ready_o) begin
                    exp_q.push_back(ref_decode(in_data_i));
                    acc_q.push_back(lat_check ? cyc : -1);
                    n_in++;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h4b5d));
        load_op_table();
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("in_ready_o", in_ready_o, 1'b1);
        @(posedge clk);

        // back-to-back stream, exact latency
        lat_check = 1;
        for (int i = 0; i < op_n; i++) begin
            send_item(make_fetch(kept_word(i), 1'b0));
        end
        send_item(make_fetch('0, 1'b0));
        for (int i = 0; i < 16; i++) begin
            send_item(make_fetch(illegal_word(), 1'b0));
        end
        for (int i = 0; i < 16; i++) begin
            send_item(make_fetch(kept_word($urandom_range(0, op_n - 1)), 1'b1));
        end
        // fetch fault on top of every decode exception
        send_item(make_fetch({op17_break, 15'($urandom())}, 1'b1));
        send_item(make_fetch({op17_syscall, 15'($urandom())}, 1'b1));
        send_item(make_fetch(illegal_word(), 1'b1));
        drain();

        lat_check = 0;
        bp_on = 1;
        for (int i = 0; i < 400; i++) begin
            send_item(random_fetch());
            if ($urandom_range(0, 3) == 0) begin
                in_valid_i <= 1'b0;
                repeat ($urandom_range(1, 3)) @(posedge clk);
            end
        end
        drain();

        @(negedge clk);
        if (n_in != n_sent || n_out != n_sent || out_valid_o) begin
            $display("%0d items sent, %0d accepted, %0d output, out_valid_o %0b after drain",
                     n_sent, n_in, n_out, out_valid_o);
            abort_run();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+.
decode_pkg.sv
stage_reg.sv
imm_group_decoder.sv
reg_group_decoder.sv
branch_group_decoder.sv
id_stage.sv
tb_id_stage.sv
